/* list.f */
+incdir+src
src/nocFlit_pkg.sv
src/nocRoute_pkg.sv
src/flitFifo.sv
src/linkReceiver.sv
src/lbdrRoute.sv
src/portSwitch.sv
src/inputPortTop.sv
bench/inputPortTb.sv

/* Makefile */
TOOL      = verilator
TOP       = inputPortTb
FILELIST  = list.f
FLAGS     = --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS = --lint-only --timing --timescale 1ns/100ps
OBJDIR    = obj_dir
LOG       = sim.log
PASS      = All tests passed

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/inputPortTb.sv */
`include "noc_consts.svh"

module inputPortTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int resetCycles   = 10;
  localparam int cyclesPerFlit = 40;

  // XY style config, west link missing
  localparam nocRoute_pkg::routeCfg_t xyCfg = '{rxy: 8'h3C, cx: 4'b1011, curAddr: 4'b0101};
  // Mixed diagonal choices, south link missing
  localparam nocRoute_pkg::routeCfg_t mixCfg = '{rxy: 8'h99, cx: 4'b0111, curAddr: 4'b1010};

  typedef enum logic [1:0] {holdNone, holdAll, holdRandom} holdMode_t;

  // Expected output flit and the port it must leave on
  typedef struct packed {
    nocFlit_pkg::flit_t     flit;
    nocRoute_pkg::portSel_t port;
  } expItem_t;

  logic                    clk;
  logic                    rst;
  nocRoute_pkg::routeCfg_t cfgIn;
  nocFlit_pkg::flit_t      linkFlit;
  logic                    linkValid;
  logic                    linkFull;
  nocRoute_pkg::portSel_t  portHold;
  nocFlit_pkg::flit_t      outFlit;
  nocRoute_pkg::portSel_t  outValid;
  logic                    routeDrop;
  logic                    framingDrop;
  logic [7:0]              dropCount;

  logic [31:0]             lfsr = 32'had9d;
  expItem_t                expQ[$];
  nocRoute_pkg::routeCfg_t curCfg;
  nocRoute_pkg::portSel_t  pktPort;
  logic                    pktOpen;
  holdMode_t               holdMode;
  int                      expDrops;
  int                      seenDrops;
  int                      sentCount;
  int                      cycleCount;
  logic                    fullSeen;
  logic                    localSeen;
  logic                    routeDropSeen;

  inputPortTop inputPortTop_inst (
    .clk        (clk),
    .rst        (rst),
    .cfgIn      (cfgIn),
    .linkFlit   (linkFlit),
    .linkValid  (linkValid),
    .linkFull   (linkFull),
    .portHold   (portHold),
    .outFlit    (outFlit),
    .outValid   (outValid),
    .routeDrop  (routeDrop),
    .framingDrop(framingDrop),
    .dropCount  (dropCount)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expV,
                                input logic [31:0] gotV);
    failRun($sformatf("Error: %s expected 0x%0h got 0x%0h", name, expV, gotV));
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic nextBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] randBits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[14:0], nextBit()};
    end
    return r;
  endfunction

  function automatic nocRoute_pkg::portSel_t holdValue();
    logic [15:0] r;
    case (holdMode)
      holdAll: return '1;
      holdRandom: begin
        r = randBits(5);
        return r[4:0];
      end
      default: return '0;
    endcase
  endfunction

  // Reference LBDR rule
  function automatic nocRoute_pkg::portSel_t refRoute(input nocRoute_pkg::routeCfg_t c,
                                                      input logic [2*`COORD_W-1:0] dst);
    nocRoute_pkg::portSel_t p;
    logic [`COORD_W-1:0]    curY;
    logic [`COORD_W-1:0]    curX;
    logic [`COORD_W-1:0]    dstY;
    logic [`COORD_W-1:0]    dstX;
    p    = '0;
    curY = c.curAddr[2*`COORD_W-1:`COORD_W];
    curX = c.curAddr[`COORD_W-1:0];
    dstY = dst[2*`COORD_W-1:`COORD_W];
    dstX = dst[`COORD_W-1:0];
    if (dst == c.curAddr) begin
      p.localPort = 1'b1;
    end else if (dstY == curY) begin
      p.east = dstX > curX;
      p.west = dstX < curX;
    end else if (dstX == curX) begin
      p.north = dstY < curY;
      p.south = dstY > curY;
    end else if (dstY < curY && dstX > curX) begin
      // Diagonal, each axis asks its own routing bit
      p.north = c.rxy[0];
      p.east  = c.rxy[2];
    end else if (dstY < curY) begin
      p.north = c.rxy[1];
      p.west  = c.rxy[4];
    end else if (dstX > curX) begin
      p.south = c.rxy[6];
      p.east  = c.rxy[3];
    end else begin
      p.south = c.rxy[7];
      p.west  = c.rxy[5];
    end
    // Links that do not exist
    p.north = p.north & c.cx[0];
    p.east  = p.east & c.cx[1];
    p.west  = p.west & c.cx[2];
    p.south = p.south & c.cx[3];
    return p;
  endfunction

  // Framing model, legal flits go to the scoreboard
  function automatic void modelFlit(input nocFlit_pkg::flit_t f);
    expItem_t e;
    if (f.flitId == nocFlit_pkg::idHeader && !pktOpen) begin
      pktOpen = 1'b1;
      pktPort = refRoute(curCfg, f.dstAddr);
    end else if (f.flitId == nocFlit_pkg::idHeader || !pktOpen) begin
      expDrops++;
      return;
    end
    e.flit = f;
    e.port = pktPort;
    expQ.push_back(e);
    if (f.flitId == nocFlit_pkg::idTail) pktOpen = 1'b0;
  endfunction

  function automatic nocFlit_pkg::flit_t makeFlit(input nocFlit_pkg::flitId_t id,
                                                  input logic [2*`COORD_W-1:0] dst);
    nocFlit_pkg::flit_t f;
    f.flitId  = id;
    f.dstAddr = dst;
    f.payload = randBits(`PAYLOAD_W);
    return f;
  endfunction

  task automatic tick();
    @(posedge clk);
    linkValid <= 1'b0;
    portHold  <= holdValue();
  endtask

  task automatic sendFlit(input nocFlit_pkg::flit_t f);
    tick();
    // Hold everything only until the FIFO has filled once
    while (linkFull) begin
      if (holdMode == holdAll) holdMode = holdRandom;
      tick();
    end
    linkFlit  <= f;
    linkValid <= 1'b1;
    sentCount++;
    modelFlit(f);
    // Two quiet edges so this flit is counted in linkFull before the next send
    tick();
    tick();
  endtask

  task automatic sendPacket(input logic [2*`COORD_W-1:0] dst, input int nPayload,
                            input int gap);
    sendFlit(makeFlit(nocFlit_pkg::idHeader, dst));
    repeat (gap) tick();
    for (int i = 0; i < nPayload; i++) begin
      sendFlit(makeFlit(nocFlit_pkg::idPayload, dst));
      repeat (gap) tick();
    end
    sendFlit(makeFlit(nocFlit_pkg::idTail, dst));
  endtask

  task automatic applyReset(input nocRoute_pkg::routeCfg_t cfg);
    tick();
    rst           <= 1'b1;
    cfgIn         <= cfg;
    curCfg        = cfg;
    pktOpen       = 1'b0;
    expDrops      = 0;
    seenDrops     = 0;
    fullSeen      = 1'b0;
    localSeen     = 1'b0;
    routeDropSeen = 1'b0;
    holdMode      = holdNone;
    repeat (resetCycles) tick();
    rst <= 1'b0;
    tick();
    assert (outValid == '0 && !routeDrop && !framingDrop && !linkFull && dropCount == '0)
      else failRun("Outputs were not idle right after reset");
  endtask

  task automatic runSuite(input nocRoute_pkg::routeCfg_t cfg);
    applyReset(cfg);
    // Every destination once, so all quadrants, local and blocked routes
    for (int d = 0; d < 16; d++) begin
      sendPacket(4'(d), 1, 0);
    end
    // Body flits after long gaps with the FIFO empty
    sendPacket(4'(randBits(4)), 3, 6);
    // Stray payload and tail, then a second header inside an open packet
    sendFlit(makeFlit(nocFlit_pkg::idPayload, cfg.curAddr));
    sendFlit(makeFlit(nocFlit_pkg::idTail, cfg.curAddr));
    sendFlit(makeFlit(nocFlit_pkg::idHeader, cfg.curAddr));
    sendFlit(makeFlit(nocFlit_pkg::idPayload, cfg.curAddr));
    sendFlit(makeFlit(nocFlit_pkg::idHeader, 4'(randBits(4))));
    sendFlit(makeFlit(nocFlit_pkg::idTail, cfg.curAddr));
    // Local port held until linkFull, then random back-pressure
    holdMode = holdAll;
    sendPacket(cfg.curAddr, 10, 0);
    holdMode = holdRandom;
    for (int n = 0; n < 24; n++) begin
      sendPacket(4'(randBits(4)), int'(randBits(3)), int'(randBits(2)));
    end
    holdMode = holdNone;
    for (int n = 0; n < 8; n++) begin
      sendPacket(4'(randBits(4)), int'(randBits(3)), int'(randBits(2)));
    end
    while (expQ.size() != 0) tick();
    repeat (4) tick();
    assert (dropCount == 8'(expDrops)) else reportMismatch("dropCount", expDrops, {24'd0, dropCount});
    assert (seenDrops == expDrops) else reportMismatch("framingDrop pulses", expDrops, seenDrops);
    assert (fullSeen) else failRun("linkFull never rose under back-pressure");
    assert (localSeen) else failRun("No flit left on the local port");
    assert (routeDropSeen) else failRun("No blocked route was flagged with routeDrop");
  endtask

  // Scoreboard, outputs sampled before the edge updates them
  always @(posedge clk) begin : checkOutputs
    expItem_t e;
    if (!rst) begin
      if (linkFull) fullSeen = 1'b1;
      if (framingDrop) seenDrops++;
      if (outValid.localPort) localSeen = 1'b1;
      if (routeDrop) routeDropSeen = 1'b1;
      if (outValid != '0 || routeDrop) begin
        assert (expQ.size() != 0) else failRun("A flit left the port when none was expected");
        e = expQ.pop_front();
        assert (outValid == e.port)
          else reportMismatch("outValid", {27'd0, e.port}, {27'd0, outValid});
        assert (routeDrop == (e.port == '0))
          else reportMismatch("routeDrop", {31'd0, e.port == '0}, {31'd0, routeDrop});
        assert (outFlit == e.flit)
          else reportMismatch("outFlit", {9'd0, e.flit}, {9'd0, outFlit});
      end
    end
  end

  // Watchdog, budget grows with every flit sent
  initial begin
    cycleCount = 0;
    forever begin
      @(posedge clk);
      cycleCount++;
      if (cycleCount > (sentCount + 1) * cyclesPerFlit + 2 * resetCycles) begin
        failRun($sformatf("Timeout after %0d cycles with %0d flits sent", cycleCount, sentCount));
      end
    end
  end

  initial begin
    rst       = 1'b1;
    cfgIn     = '0;
    linkFlit  = '0;
    linkValid = 1'b0;
    portHold  = '0;
    holdMode  = holdNone;
    sentCount = 0;
    runSuite(xyCfg);
    runSuite(mixCfg);
    $display("All tests passed");
    $finish;
  end

endmodule

/* src/inputPortTop.sv */
module inputPortTop (
  input  logic                    clk,
  input  logic                    rst,
  input  nocRoute_pkg::routeCfg_t cfgIn,
  input  nocFlit_pkg::flit_t      linkFlit,
  input  logic                    linkValid,
  output logic                    linkFull,
  input  nocRoute_pkg::portSel_t  portHold,
  output nocFlit_pkg::flit_t      outFlit,
  output nocRoute_pkg::portSel_t  outValid,
  output logic                    routeDrop,
  output logic                    framingDrop,
  output logic [7:0]              dropCount
);

  logic                   push;
  nocFlit_pkg::flit_t     wrFlit;
  logic                   pop;
  nocFlit_pkg::flit_t     headFlit;
  logic                   empty;
  nocRoute_pkg::portSel_t nextRoute;
  nocRoute_pkg::portSel_t route;

  // Link side, FIFO full goes straight out as link back-pressure
  linkReceiver linkReceiver_inst (
    .clk        (clk),
    .rst        (rst),
    .linkFlit   (linkFlit),
    .linkValid  (linkValid),
    .fifoFull   (linkFull),
    .push       (push),
    .wrFlit     (wrFlit),
    .framingDrop(framingDrop),
    .dropCount  (dropCount)
  );

  flitFifo #(.itemT(nocFlit_pkg::flit_t)) flitFifo_inst (
    .clk     (clk),
    .rst     (rst),
    .push    (push),
    .wrItem  (wrFlit),
    .pop     (pop),
    .headItem(headFlit),
    .empty   (empty),
    .full    (linkFull)
  );

  // Route unit and switch both look at the FIFO head
  lbdrRoute lbdrRoute_inst (
    .clk      (clk),
    .rst      (rst),
    .cfgIn    (cfgIn),
    .headFlit (headFlit),
    .empty    (empty),
    .pop      (pop),
    .nextRoute(nextRoute),
    .route    (route)
  );

  portSwitch portSwitch_inst (
    .clk      (clk),
    .rst      (rst),
    .headFlit (headFlit),
    .empty    (empty),
    .nextRoute(nextRoute),
    .route    (route),
    .portHold (portHold),
    .pop      (pop),
    .outFlit  (outFlit),
    .outValid (outValid),
    .routeDrop(routeDrop)
  );

endmodule

/* src/portSwitch.sv */
module portSwitch (
  input  logic                   clk,
  input  logic                   rst,
  input  nocFlit_pkg::flit_t     headFlit,
  input  logic                   empty,
  input  nocRoute_pkg::portSel_t nextRoute,
  input  nocRoute_pkg::portSel_t route,
  input  nocRoute_pkg::portSel_t portHold,
  output logic                   pop,
  output nocFlit_pkg::flit_t     outFlit,
  output nocRoute_pkg::portSel_t outValid,
  output logic                   routeDrop
);

  nocRoute_pkg::portSel_t effRoute;
  logic                   isHeader;
  logic                   held;
  logic                   noRoute;

  assign isHeader = (headFlit.flitId == nocFlit_pkg::idHeader);

  // Header uses the route being computed now
  // Body flits use the one latched at their header
  assign effRoute = isHeader ? nextRoute : route;
  assign noRoute  = (effRoute == '0);

  // Back-pressure only from the port this flit wants
  assign held = |(effRoute & portHold);

  // A blocked route never matches a hold, so it drains
  assign pop = !empty && !held;

  // Output stage
  always_ff @(posedge clk) begin
    if (pop) begin
      outFlit <= headFlit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid  <= '0;
      routeDrop <= 1'b0;
    end else begin
      outValid  <= pop ? effRoute : '0;
      // Discarded flit is flagged instead of leaving
      routeDrop <= pop && noRoute;
    end
  end

  outOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(outValid));

endmodule

/* src/lbdrRoute.sv */
`include "noc_consts.svh"

module lbdrRoute (
  input  logic                   clk,
  input  logic                   rst,
  input  nocRoute_pkg::routeCfg_t cfgIn,
  input  nocFlit_pkg::flit_t     headFlit,
  input  logic                   empty,
  input  logic                   pop,
  output nocRoute_pkg::portSel_t nextRoute,
  output nocRoute_pkg::portSel_t route
);

  nocRoute_pkg::routeCfg_t cfg;
  logic [`COORD_W-1:0]     xCur;
  logic [`COORD_W-1:0]     yCur;
  logic [`COORD_W-1:0]     xDst;
  logic [`COORD_W-1:0]     yDst;
  logic                    goN;
  logic                    goE;
  logic                    goW;
  logic                    goS;
  logic                    headerPop;

  // Configuration is only taken while reset is held
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg <= cfgIn;
    end
  end

  // Split addresses into mesh coordinates
  assign xCur = cfg.curAddr[`COORD_W-1:0];
  assign yCur = cfg.curAddr[2*`COORD_W-1:`COORD_W];
  assign xDst = headFlit.dstAddr[`COORD_W-1:0];
  assign yDst = headFlit.dstAddr[2*`COORD_W-1:`COORD_W];

  // Quadrant comparators
  // North is toward smaller y
  assign goN = yDst < yCur;
  assign goS = yCur < yDst;
  assign goE = xCur < xDst;
  assign goW = xDst < xCur;

  // LBDR port logic
  // Straight moves go alone, diagonal moves pick by the routing bits
  always_comb begin
    nextRoute.north = ((goN & ~goE & ~goW) | (goN & goE & cfg.rxy[0]) |
                       (goN & goW & cfg.rxy[1])) & cfg.cx[0];
    nextRoute.east  = ((goE & ~goN & ~goS) | (goE & goN & cfg.rxy[2]) |
                       (goE & goS & cfg.rxy[3])) & cfg.cx[1];
    nextRoute.west  = ((goW & ~goN & ~goS) | (goW & goN & cfg.rxy[4]) |
                       (goW & goS & cfg.rxy[5])) & cfg.cx[2];
    nextRoute.south = ((goS & ~goE & ~goW) | (goS & goE & cfg.rxy[6]) |
                       (goS & goW & cfg.rxy[7])) & cfg.cx[3];
    // Arrived, no link involved so no connectivity mask
    nextRoute.localPort = ~(goN | goS | goE | goW);
  end

  assign headerPop = pop && !empty && (headFlit.flitId == nocFlit_pkg::idHeader);

  // Route latched per packet
  // Held across payload, tail and empty gaps until the next header
  always_ff @(posedge clk) begin
    if (rst) begin
      route <= '0;
    end else if (headerPop) begin
      route <= nextRoute;
    end
  end

  // Holds only for configurations with consistent diagonal routing bits
  routeOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(route));

endmodule

/* src/linkReceiver.sv */
module linkReceiver (
  input  logic               clk,
  input  logic               rst,
  input  nocFlit_pkg::flit_t linkFlit,
  input  logic               linkValid,
  input  logic               fifoFull,
  output logic               push,
  output nocFlit_pkg::flit_t wrFlit,
  output logic               framingDrop,
  output logic [7:0]         dropCount
);

  nocFlit_pkg::flit_t rxFlit;
  logic               rxValid;
  logic               pktOpen;
  logic               legal;

  // Link capture stage
  always_ff @(posedge clk) begin
    if (rst) begin
      rxValid <= 1'b0;
    end else begin
      rxValid <= linkValid;
    end
  end

  always_ff @(posedge clk) begin
    rxFlit <= linkFlit;
  end

  // Framing rule
  // Header opens a packet, payload and tail only inside one
  always_comb begin
    case (rxFlit.flitId)
      nocFlit_pkg::idHeader:  legal = !pktOpen;
      nocFlit_pkg::idPayload: legal = pktOpen;
      nocFlit_pkg::idTail:    legal = pktOpen;
      default:                legal = 1'b0;
    endcase
  end

  // Full is judged at push time, so a late flit is dropped instead of overflowing
  assign push        = rxValid && legal && !fifoFull;
  assign wrFlit      = rxFlit;
  // Illegal framing or no room in the FIFO
  assign framingDrop = rxValid && (!legal || fifoFull);

  // Packet state only moves on accepted flits
  // A stray header leaves the open packet open
  always_ff @(posedge clk) begin
    if (rst) begin
      pktOpen <= 1'b0;
    end else if (push) begin
      if (rxFlit.flitId == nocFlit_pkg::idHeader) begin
        pktOpen <= 1'b1;
      end else if (rxFlit.flitId == nocFlit_pkg::idTail) begin
        pktOpen <= 1'b0;
      end
    end
  end

  // Saturating drop counter
  always_ff @(posedge clk) begin
    if (rst) begin
      dropCount <= '0;
    end else if (framingDrop && dropCount != 8'hFF) begin
      dropCount <= dropCount + 1'b1;
    end
  end

  noPushOnDrop: assert property (@(posedge clk) disable iff (rst) !(push && framingDrop));

endmodule

/* src/flitFifo.sv */
`include "noc_consts.svh"

module flitFifo #(
  parameter type itemT = nocFlit_pkg::flit_t,
  parameter int depth = `FIFO_DEPTH
) (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  itemT wrItem,
  input  logic pop,
  output itemT headItem,
  output logic empty,
  output logic full
);

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntW = $clog2(depth + 1);

  itemT            mem [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;

  // Wraps at depth, so depth need not be a power of two
  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
    if (ptr == ptrW'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Fall-through head
  // An incoming item is visible at once when storage is empty
  assign headItem = (count == '0) ? wrItem : mem[rdPtr];
  assign empty    = (count == '0) && !push;
  assign full     = (count == cntW'(depth));

  // Storage array
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= wrItem;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      // Push and pop together leave the count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producer must watch full, consumer must watch empty
  pushNotFull: assert property (@(posedge clk) disable iff (rst) push |-> !full);
  popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

/* src/nocRoute_pkg.sv */
`include "noc_consts.svh"

package nocRoute_pkg;

  // Per-router LBDR configuration, loaded during reset
  // rxy bit order, LSB first: ne, nw, en, es, wn, ws, se, sw
  // cx bit order, LSB first: n, e, w, s
  // curAddr holds y above x, same as a flit's dstAddr
  typedef struct packed {
    logic [7:0]               rxy;
    logic [3:0]               cx;
    logic [2*`COORD_W-1:0]    curAddr;
  } routeCfg_t;

  // One bit per output port
  // Used both for route decisions and for per-port valid and hold
  typedef struct packed {
    logic north;
    logic east;
    logic west;
    logic south;
    logic localPort;
  } portSel_t;

endpackage

/* src/nocFlit_pkg.sv */
`include "noc_consts.svh"

package nocFlit_pkg;

  // Flit identifier carried in the top bits of every flit
  typedef enum logic [2:0] {
    idHeader  = `FLIT_HEADER,
    idPayload = `FLIT_PAYLOAD,
    idTail    = `FLIT_TAIL
  } flitId_t;

  // Flit as it travels on the link and through the port
  // Address is y coordinate above x coordinate
  // Only the header's dstAddr is used for routing
  typedef struct packed {
    flitId_t                  flitId;
    logic [2*`COORD_W-1:0]    dstAddr;
    logic [`PAYLOAD_W-1:0]    payload;
  } flit_t;

endpackage

/* src/noc_consts.svh */
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Width of one mesh coordinate on the 4x4 grid
`define COORD_W 2

// Flit payload width
`define PAYLOAD_W 16

// Flit identifier codes
// One-hot, so a corrupted id never aliases a legal one
`define FLIT_HEADER  3'b001
`define FLIT_PAYLOAD 3'b010
`define FLIT_TAIL    3'b100

// Flit FIFO entries per input port
`define FIFO_DEPTH 8

`endif
